/* include/pito_settings.svh */
`ifndef PITO_SETTINGS_SVH
`define PITO_SETTINGS_SVH

// ==========================================================================
// barrel core sizing
// ==========================================================================

// harts sharing the pipeline
// at least 3 so a write lands before the same hart reads again
`define PITO_NUM_HARTS      4
// hart index width
`define PITO_HART_CNT_W     2

// register width and index width
`define PITO_XLEN           32
`define PITO_REG_ADDR_W     5

// instruction words per hart region
`define PITO_HART_WORDS     16
// word address into the whole instruction memory
`define PITO_IMEM_ADDR_W    6
// byte address, two bits wider than the word address
`define PITO_PC_W           8

`endif

/* logic/pito_pkg.sv */
`default_nettype none

`include "pito_settings.svh"

package pito_pkg;

    // basic scalar types
    typedef logic [`PITO_XLEN-1:0]        word_t;
    typedef logic [`PITO_HART_CNT_W-1:0]  hart_t;
    typedef logic [`PITO_REG_ADDR_W-1:0]  reg_idx_t;
    typedef logic [`PITO_PC_W-1:0]        pc_t;
    typedef logic [`PITO_IMEM_ADDR_W-1:0] imem_addr_t;

    // kept rv32i operations, anything else decodes to OP_NOP
    typedef enum logic [4:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
        OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_LUI
    } rv32_opcode_e;

    // alu functions
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    // issued fetch
    typedef struct packed {
        logic  valid;
        hart_t hart;
        pc_t   pc;
    } fetch_item_t;

    // decode stage register
    typedef struct packed {
        logic         valid;
        hart_t        hart;
        pc_t          pc;
        rv32_opcode_e op;
        alu_op_e      alu_op;
        reg_idx_t     rd;
        word_t        op1;
        word_t        op2;
        logic         we;
    } decoded_t;

    // register file write port
    typedef struct packed {
        logic     en;
        hart_t    hart;
        reg_idx_t idx;
        word_t    data;
    } reg_write_t;

    // one retired register write
    typedef struct packed {
        logic     valid;
        hart_t    hart;
        pc_t      pc;
        reg_idx_t rd;
        word_t    value;
    } retire_t;

endpackage

`default_nettype wire

/* logic/pito_hart_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pito_settings.svh"

module pito_hart_fetch (
    input  logic                  clk,
    input  logic                  pito_io_rst_n,
    input  logic                  prog_mode,
    input  logic                  imem_w_en,
    input  pito_pkg::imem_addr_t  imem_waddr,
    input  pito_pkg::word_t       imem_wdata,
    output pito_pkg::fetch_item_t fetch,
    output pito_pkg::word_t       instr
);
    import pito_pkg::*;

    localparam int NumHarts = `PITO_NUM_HARTS;

    hart_t       hart_cnt;
    pc_t         pc [NumHarts];
    fetch_item_t issue_q;
    word_t       imem [1 << `PITO_IMEM_ADDR_W];

    // first byte of a hart region
    function automatic pc_t hart_base(input int unsigned h);
        return pc_t'(h * `PITO_HART_WORDS * 4);
    endfunction

    // step by four, back to base after the last word
    function automatic pc_t next_pc(input pc_t cur, input int unsigned h);
        pc_t last;
        last = hart_base(h) + pc_t'((`PITO_HART_WORDS - 1) * 4);
        if (cur == last) begin
            return hart_base(h);
        end
        return cur + pc_t'(4);
    endfunction

    // ======================================================================
    // round robin scheduler
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!pito_io_rst_n) begin
            hart_cnt <= '0;
        end else if (hart_cnt == hart_t'(NumHarts - 1)) begin
            hart_cnt <= '0;
        end else begin
            hart_cnt <= hart_cnt + 1'b1;
        end
    end

    // per hart pc, parked at base while loading
    always_ff @(posedge clk) begin
        for (int i = 0; i < NumHarts; i++) begin
            if (!pito_io_rst_n || prog_mode) begin
                pc[i] <= hart_base(i);
            end else if (hart_t'(i) == hart_cnt) begin
                pc[i] <= next_pc(pc[i], i);
            end
        end
    end

    // issue the scheduled hart
    always_ff @(posedge clk) begin
        issue_q <= '{valid: !prog_mode, hart: hart_cnt, pc: pc[hart_cnt]};
        if (!pito_io_rst_n) begin
            issue_q.valid <= 1'b0;
        end
    end

    // ======================================================================
    // instruction memory
    // ======================================================================
    always_ff @(posedge clk) begin
        if (imem_w_en) begin
            imem[imem_waddr] <= imem_wdata;
        end
        // word address from byte pc
        instr <= imem[issue_q.pc[`PITO_PC_W-1:2]];
    end

    // item follows its word by one cycle
    always_ff @(posedge clk) begin
        fetch <= issue_q;
        if (!pito_io_rst_n) begin
            fetch.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/pito_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module pito_decoder (
    input  logic                  clk,
    input  logic                  pito_io_rst_n,
    input  pito_pkg::fetch_item_t fetch,
    input  pito_pkg::word_t       instr,
    output pito_pkg::reg_idx_t    rs1_addr,
    output pito_pkg::reg_idx_t    rs2_addr,
    output pito_pkg::hart_t       rd_hart,
    input  pito_pkg::word_t       rs1_data,
    input  pito_pkg::word_t       rs2_data,
    output pito_pkg::decoded_t    decoded
);
    import pito_pkg::*;

    // major opcodes
    localparam logic [6:0] OpcOp    = 7'b0110011;
    localparam logic [6:0] OpcOpImm = 7'b0010011;
    localparam logic [6:0] OpcLui   = 7'b0110111;

    logic [6:0]   opc;
    logic [2:0]   funct3;
    logic [6:0]   funct7;
    logic         is_rtype;
    logic         is_itype;
    logic         alt;
    logic         r_legal;
    logic         i_legal;
    logic         is_shift;
    word_t        imm_i;
    word_t        imm_sh;
    word_t        imm_u;
    alu_op_e      alu;
    rv32_opcode_e op;
    decoded_t     dec_next;

    // instruction fields
    assign opc    = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register read, same cycle
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_hart  = fetch.hart;

    assign is_rtype = (opc == OpcOp);
    assign is_itype = (opc == OpcOpImm);
    assign alt      = (funct7 == 7'b0100000);
    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    // funct7 must be zero, or the alt pattern on sub and sra
    assign r_legal = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
    assign i_legal = !is_shift || (funct7 == 7'b0) || (alt && funct3 == 3'b101);

    // immediates
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_sh = {27'b0, instr[24:20]};
    assign imm_u  = {instr[31:12], 12'b0};

    // alu function from funct3 and funct7
    always_comb begin
        case (funct3)
            3'b000:  alu = (is_rtype && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  alu = ALU_SLL;
            3'b010:  alu = ALU_SLT;
            3'b011:  alu = ALU_SLTU;
            3'b100:  alu = ALU_XOR;
            3'b101:  alu = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu = ALU_OR;
            default: alu = ALU_AND;
        endcase
    end

    // kept operation, register or immediate form
    always_comb begin
        op = OP_NOP;
        if (opc == OpcLui) begin
            op = OP_LUI;
        end else if (is_rtype && r_legal) begin
            case (alu)
                ALU_ADD:  op = OP_ADD;
                ALU_SUB:  op = OP_SUB;
                ALU_SLL:  op = OP_SLL;
                ALU_SLT:  op = OP_SLT;
                ALU_SLTU: op = OP_SLTU;
                ALU_XOR:  op = OP_XOR;
                ALU_SRL:  op = OP_SRL;
                ALU_SRA:  op = OP_SRA;
                ALU_OR:   op = OP_OR;
                default:  op = OP_AND;
            endcase
        end else if (is_itype && i_legal) begin
            case (alu)
                ALU_SLL:  op = OP_SLLI;
                ALU_SLT:  op = OP_SLTI;
                ALU_SLTU: op = OP_SLTIU;
                ALU_XOR:  op = OP_XORI;
                ALU_SRL:  op = OP_SRLI;
                ALU_SRA:  op = OP_SRAI;
                ALU_OR:   op = OP_ORI;
                ALU_AND:  op = OP_ANDI;
                default:  op = OP_ADDI;
            endcase
        end
    end

    // operands and write enable
    always_comb begin
        dec_next.valid  = fetch.valid;
        dec_next.hart   = fetch.hart;
        dec_next.pc     = fetch.pc;
        dec_next.op     = op;
        dec_next.alu_op = alu;
        dec_next.rd     = instr[11:7];
        dec_next.op1    = rs1_data;
        if (is_rtype) begin
            dec_next.op2 = rs2_data;
        end else if (opc == OpcLui) begin
            dec_next.op2 = imm_u;
        end else if (is_shift) begin
            dec_next.op2 = imm_sh;
        end else begin
            dec_next.op2 = imm_i;
        end
        // x0 target never writes
        dec_next.we = (op != OP_NOP) && (instr[11:7] != '0);
    end

    always_ff @(posedge clk) begin
        decoded <= dec_next;
        if (!pito_io_rst_n) begin
            decoded.valid <= 1'b0;
            decoded.we    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/pito_barrel_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pito_settings.svh"

module pito_barrel_regfile (
    input  logic                 clk,
    input  pito_pkg::hart_t      rd_hart,
    input  pito_pkg::reg_idx_t   rs1_addr,
    input  pito_pkg::reg_idx_t   rs2_addr,
    output pito_pkg::word_t      rs1_data,
    output pito_pkg::word_t      rs2_data,
    input  pito_pkg::reg_write_t wr
);
    import pito_pkg::*;

    localparam int NumRegs = 1 << `PITO_REG_ADDR_W;

    // ======================================================================
    // one bank of registers per hart
    // ======================================================================
    word_t regs [`PITO_NUM_HARTS][NumRegs];

    // asynchronous read from the hart in decode
    // x0 reads zero whatever the bank holds
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rd_hart][rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rd_hart][rs2_addr];

    // write from the write stage
    // hart here is the one retiring, not the one reading
    always_ff @(posedge clk) begin
        if (wr.en) begin
            regs[wr.hart][wr.idx] <= wr.data;
        end
    end

endmodule

`default_nettype wire

/* logic/pito_execute.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pito_settings.svh"

module pito_execute (
    input  logic                 clk,
    input  logic                 pito_io_rst_n,
    input  pito_pkg::decoded_t   decoded,
    output pito_pkg::reg_write_t wr,
    output pito_pkg::retire_t    retire
);
    import pito_pkg::*;

    // shift amount width
    localparam int ShW = $clog2(`PITO_XLEN);

    word_t          op1;
    word_t          op2;
    logic [ShW-1:0] shamt;
    word_t          alu_res;
    word_t          result;
    logic           commit;

    assign op1   = decoded.op1;
    assign op2   = decoded.op2;
    // low bits of operand two only
    assign shamt = op2[ShW-1:0];

    // ======================================================================
    // alu
    // ======================================================================
    always_comb begin
        case (decoded.alu_op)
            ALU_ADD:  alu_res = op1 + op2;
            ALU_SUB:  alu_res = op1 - op2;
            ALU_SLL:  alu_res = op1 << shamt;
            // signed compare
            ALU_SLT:  alu_res = word_t'($signed(op1) < $signed(op2));
            ALU_SLTU: alu_res = word_t'(op1 < op2);
            ALU_XOR:  alu_res = op1 ^ op2;
            ALU_SRL:  alu_res = op1 >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  alu_res = word_t'($signed(op1) >>> shamt);
            ALU_OR:   alu_res = op1 | op2;
            ALU_AND:  alu_res = op1 & op2;
            default:  alu_res = '0;
        endcase
    end

    // lui carries the u immediate in operand two
    assign result = (decoded.op == OP_LUI) ? op2 : alu_res;

    // only valid items with a real target
    assign commit = decoded.valid && decoded.we;

    // ======================================================================
    // write stage register
    // ======================================================================
    always_ff @(posedge clk) begin
        wr.en   <= commit;
        wr.hart <= decoded.hart;
        wr.idx  <= decoded.rd;
        wr.data <= result;
        if (!pito_io_rst_n) begin
            wr.en <= 1'b0;
        end
    end

    // retire mirrors the register write, plus pc
    always_ff @(posedge clk) begin
        retire.valid <= commit;
        retire.hart  <= decoded.hart;
        retire.pc    <= decoded.pc;
        retire.rd    <= decoded.rd;
        retire.value <= result;
        if (!pito_io_rst_n) begin
            retire.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/pito_barrel_core.sv */
`timescale 1ns/1ns
`default_nettype none

module pito_barrel_core (
    input  logic                 clk,
    input  logic                 pito_io_rst_n,
    input  logic                 pito_io_imem_w_en,
    input  pito_pkg::imem_addr_t pito_io_imem_addr,
    input  pito_pkg::word_t      pito_io_imem_data,
    input  logic                 pito_io_program,
    output pito_pkg::retire_t    retire
);
    import pito_pkg::*;

    // fetch to decode
    fetch_item_t fetch;
    word_t       instr;

    // decode to register file
    reg_idx_t    rs1_addr;
    reg_idx_t    rs2_addr;
    hart_t       rd_hart;
    word_t       rs1_data;
    word_t       rs2_data;

    // decode to execute, execute back to register file
    decoded_t    decoded;
    reg_write_t  wr;

    // ======================================================================
    // fetch, one hart per cycle
    // ======================================================================
    pito_hart_fetch fetch_i (
        .clk           (clk),
        .pito_io_rst_n (pito_io_rst_n),
        .prog_mode     (pito_io_program),
        .imem_w_en     (pito_io_imem_w_en),
        .imem_waddr    (pito_io_imem_addr),
        .imem_wdata    (pito_io_imem_data),
        .fetch         (fetch),
        .instr         (instr)
    );

    // decode and operand read
    pito_decoder decoder_i (
        .clk           (clk),
        .pito_io_rst_n (pito_io_rst_n),
        .fetch         (fetch),
        .instr         (instr),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rd_hart       (rd_hart),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .decoded       (decoded)
    );

    // banked registers
    pito_barrel_regfile regfile_i (
        .clk           (clk),
        .rd_hart       (rd_hart),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wr            (wr)
    );

    // alu, write back and retire
    pito_execute execute_i (
        .clk           (clk),
        .pito_io_rst_n (pito_io_rst_n),
        .decoded       (decoded),
        .wr            (wr),
        .retire        (retire)
    );

endmodule

`default_nettype wire

/* bench/pito_barrel_core_checker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pito_settings.svh"

module pito_barrel_core_checker (
    input logic              clk,
    input logic              pito_io_rst_n,
    input logic              pito_io_program,
    input pito_pkg::retire_t retire
);
    import pito_pkg::*;

    localparam int NumHarts = `PITO_NUM_HARTS;

    // failed assertions so far
    int unsigned assert_fails = 0;

    // scheduler order, wraps after the last hart
    function automatic hart_t next_hart(input hart_t h);
        return (h == hart_t'(NumHarts - 1)) ? hart_t'(0) : hart_t'(h + 1'b1);
    endfunction

    // ======================================================================
    // retire port rules
    // ======================================================================

    // quiet in the cycle after reset
    a_quiet_after_reset: assert property (@(posedge clk)
        !pito_io_rst_n |=> !retire.valid)
    else begin
        $error("retire valid in the cycle after reset");
        assert_fails++;
    end

    // x0 never retires
    a_no_x0_retire: assert property (@(posedge clk) disable iff (!pito_io_rst_n)
        retire.valid |-> retire.rd != '0)
    else begin
        $error("retire with destination x0");
        assert_fails++;
    end

    // last valid fetch drains within three cycles of loading mode
    a_drain_on_program: assert property (@(posedge clk) disable iff (!pito_io_rst_n)
        pito_io_program [*5] |-> !retire.valid)
    else begin
        $error("retire more than three cycles after program mode");
        assert_fails++;
    end

    // back to back retires come from neighbouring harts
    a_round_robin: assert property (@(posedge clk) disable iff (!pito_io_rst_n)
        (retire.valid && $past(retire.valid)) |-> retire.hart == next_hart($past(retire.hart)))
    else begin
        $error("retire hart out of round robin order");
        assert_fails++;
    end

endmodule

bind pito_barrel_core pito_barrel_core_checker checker_i (
    .clk             (clk),
    .pito_io_rst_n   (pito_io_rst_n),
    .pito_io_program (pito_io_program),
    .retire          (retire)
);

`default_nettype wire

/* bench/pito_barrel_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pito_settings.svh"

module pito_barrel_core_tb;
    import pito_pkg::*;

    localparam int NumHarts       = `PITO_NUM_HARTS;
    localparam int HartWords      = `PITO_HART_WORDS;
    // two full passes over every region
    localparam int RunCycles      = NumHarts * 2 * HartWords;
    localparam int DrainCycles    = 6;
    localparam int WatchdogCycles = RunCycles + NumHarts * HartWords + 200;
    // addi x0, x0, 0
    localparam logic [31:0] NopWord = 32'h0000_0013;

    logic       clk;
    logic       pito_io_rst_n;
    logic       pito_io_imem_w_en;
    imem_addr_t pito_io_imem_addr;
    word_t      pito_io_imem_data;
    logic       pito_io_program;
    retire_t    retire;

    integer seed    = 32'hf07f4231;
    int     errors  = 0;
    int     checks  = 0;
    logic   loading = 1'b1;

    // program image, then per hart model state
    logic [31:0]       prog [NumHarts * HartWords];
    logic [31:0][31:0] model_regs [NumHarts];
    int                model_idx [NumHarts];
    int                retired [NumHarts];

    pito_barrel_core dut_i (
        .clk               (clk),
        .pito_io_rst_n     (pito_io_rst_n),
        .pito_io_imem_w_en (pito_io_imem_w_en),
        .pito_io_imem_addr (pito_io_imem_addr),
        .pito_io_imem_data (pito_io_imem_data),
        .pito_io_program   (pito_io_program),
        .retire            (retire)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // instruction encoding
    // ======================================================================
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // ======================================================================
    // reference model, rv32i semantics of the kept operations
    // ======================================================================
    function automatic void predict_write(input logic [31:0] ins,
                                          input logic [31:0][31:0] regs,
                                          output logic we, output logic [4:0] rd,
                                          output logic [31:0] val);
        logic [6:0]  opc;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic        legal;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        rd    = ins[11:7];
        a     = (ins[19:15] == 5'd0) ? 32'd0 : regs[ins[19:15]];
        // sign extended i immediate, low five bits double as shamt
        b     = {{20{ins[31]}}, ins[31:20]};
        val   = 32'd0;
        legal = 1'b0;
        if (opc == 7'b0110111) begin
            val   = {ins[31:12], 12'd0};
            legal = 1'b1;
        end else if (opc == 7'b0110011 || opc == 7'b0010011) begin
            if (opc == 7'b0110011) begin
                // alt funct7 only on sub and sra
                b     = (ins[24:20] == 5'd0) ? 32'd0 : regs[ins[24:20]];
                legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            end else begin
                legal = (f3 != 3'd1 && f3 != 3'd5) || (f7 == 7'h00) ||
                        (f7 == 7'h20 && f3 == 3'd5);
            end
            case (f3)
                3'd0: val = (opc == 7'b0110011 && f7[5]) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: val = (a < b) ? 32'd1 : 32'd0;
                3'd4: val = a ^ b;
                3'd5: begin
                    if (f7[5]) begin
                        val = $signed(a) >>> b[4:0];
                    end else begin
                        val = a >> b[4:0];
                    end
                end
                3'd6: val = a | b;
                default: val = a & b;
            endcase
        end
        we = legal && (rd != 5'd0);
    endfunction

    // ======================================================================
    // program build and load
    // ======================================================================
    task automatic build_program();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          idx;
        int          pick;
        pick = 0;
        for (int h = 0; h < NumHarts; h++) begin
            for (int w = 0; w < HartWords; w++) begin
                idx = h * HartWords + w;
                r   = $random(seed);
                rd  = {2'b00, r[6:4]};
                // f3 cycles so every alu function shows up
                f3  = pick[2:0];
                if (w < 7) begin
                    // x1..x7 from x0, addi or lui
                    rd = 5'(w + 1);
                    if (r[31]) begin
                        prog[idx] = {r[19:0], rd, 7'b0110111};
                    end else begin
                        prog[idx] = itype_word(r[11:0], 5'd0, 3'd0, rd);
                    end
                end else if (r[3:0] == 4'd0) begin
                    prog[idx] = NopWord;
                end else if (r[3:0] == 4'd1) begin
                    // store opcode, not a kept operation
                    prog[idx] = {r[31:7], 7'b0100011};
                end else if (r[3:0] < 4'd9) begin
                    f7        = ((f3 == 3'd0 || f3 == 3'd5) && r[13]) ? 7'h20 : 7'h00;
                    prog[idx] = rtype_word(f7, {2'b00, r[12:10]}, {2'b00, r[9:7]}, f3, rd);
                    pick++;
                end else begin
                    if (f3 == 3'd1) begin
                        imm = {7'h00, r[24:20]};
                    end else if (f3 == 3'd5) begin
                        imm = {(r[13] ? 7'h20 : 7'h00), r[24:20]};
                    end else begin
                        imm = r[31:20];
                    end
                    prog[idx] = itype_word(imm, {2'b00, r[9:7]}, f3, rd);
                    pick++;
                end
            end
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < NumHarts * HartWords; a++) begin
            @(negedge clk);
            pito_io_imem_w_en = 1'b1;
            pito_io_imem_addr = imem_addr_t'(a);
            pito_io_imem_data = prog[a];
        end
        @(negedge clk);
        pito_io_imem_w_en = 1'b0;
    endtask

    // ======================================================================
    // retire comparison
    // ======================================================================
    task automatic check_retire();
        int          h;
        int          steps;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] val;
        pc_t         exp_pc;
        h     = int'(retire.hart);
        we    = 1'b0;
        steps = 0;
        // step past words that write nothing
        while (!we && steps < HartWords) begin
            predict_write(prog[h * HartWords + model_idx[h]], model_regs[h], we, rd, val);
            exp_pc       = pc_t'((h * HartWords + model_idx[h]) * 4);
            model_idx[h] = (model_idx[h] + 1) % HartWords;
            steps++;
        end
        checks++;
        if (!we) begin
            errors++;
            $display("hart %0d retired at %0t but its program writes no register", h, $time);
        end else if (retire.pc !== exp_pc || retire.rd !== rd || retire.value !== val) begin
            errors++;
            $display("ERR %0t: hart %0d pc %h x%0d = %h, expected pc %h x%0d = %h",
                     $time, h, retire.pc, retire.rd, retire.value, exp_pc, rd, val);
        end
        if (we) begin
            model_regs[h][rd] = val;
            retired[h]++;
        end
    endtask

    task automatic check_counts();
        int          expect_cnt;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] val;
        for (int h = 0; h < NumHarts; h++) begin
            expect_cnt = 0;
            for (int w = 0; w < HartWords; w++) begin
                predict_write(prog[h * HartWords + w], model_regs[h], we, rd, val);
                if (we) begin
                    expect_cnt += 2;
                end
            end
            checks++;
            if (retired[h] != expect_cnt) begin
                errors++;
                $display("hart %0d retired %0d register writes in two passes instead of %0d",
                         h, retired[h], expect_cnt);
            end
        end
    endtask

    // sampled on the falling edge, away from register updates
    always @(negedge clk) begin
        if (pito_io_rst_n === 1'b1 && loading && retire.valid !== 1'b0) begin
            errors++;
            $display("a retire appeared at %0t while the program was loading", $time);
        end else if (!loading && retire.valid === 1'b1) begin
            check_retire();
        end
    end

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        pito_io_rst_n     = 1'b0;
        pito_io_program   = 1'b1;
        pito_io_imem_w_en = 1'b0;
        pito_io_imem_addr = '0;
        pito_io_imem_data = '0;
        for (int h = 0; h < NumHarts; h++) begin
            model_regs[h] = '0;
            model_idx[h]  = 0;
            retired[h]    = 0;
        end
        build_program();
        repeat (3) @(negedge clk);
        pito_io_rst_n = 1'b1;
        load_program();
        // idle with harts parked
        repeat (4) @(negedge clk);
        loading         = 1'b0;
        pito_io_program = 1'b0;
        repeat (RunCycles) @(negedge clk);
        pito_io_program = 1'b1;
        repeat (DrainCycles) @(negedge clk);
        check_counts();
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut_i.checker_i.assert_fails);
        if (errors == 0 && dut_i.checker_i.assert_fails == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("the run timed out after %0d cycles", WatchdogCycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* pito_barrel_core.f */
+incdir+include
logic/pito_pkg.sv
logic/pito_hart_fetch.sv
logic/pito_decoder.sv
logic/pito_barrel_regfile.sv
logic/pito_execute.sv
logic/pito_barrel_core.sv
bench/pito_barrel_core_checker.sv
bench/pito_barrel_core_tb.sv
